/* files.f */
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_exec.sv
rtl/cpu_memory.sv
rtl/cpu_regfile.sv
rtl/cpu_core.sv
test/tb_cpu_core.sv

/* rtl/cpu_core.sv */
`include "cpu_defines.svh"

module cpu_core (
	input  logic clk,
	input  logic i_rst,
	output logic o_running,
	output logic o_ibus_access,
	output logic [`CPU_ADDR_W-1:0] o_ibus_addr,
	input  logic [`CPU_XLEN-1:0] i_ibus_data,
	input  logic i_ibus_ack,
	output logic o_dbus_access,
	output logic [`CPU_ADDR_W-1:0] o_dbus_addr,
	output logic o_dbus_wr_en,
	output logic [`CPU_XLEN-1:0] o_dbus_wr_val,
	input  logic [`CPU_XLEN-1:0] i_dbus_data,
	input  logic i_dbus_ack
);

	cpu_pipe_pkg::fd_t fd;
	cpu_pipe_pkg::de_t de;
	cpu_pipe_pkg::em_t em;
	cpu_pipe_pkg::mw_t mw;
	cpu_isa_pkg::reg_sel_t d_ra_sel, d_rb_sel;
	cpu_isa_pkg::reg_sel_t e_ra_sel, e_rb_sel;
	cpu_isa_pkg::reg_sel_t rf_ra_sel, rf_rb_sel;
	logic [`CPU_XLEN-1:0] rf_ra, rf_rb, fwd_ra, fwd_rb;
	logic [`CPU_XLEN-1:0] branch_pc;
	logic branch_taken, halted, mem_stall, stall;

	assign stall = mem_stall | (o_ibus_access & ~i_ibus_ack);
	assign o_running = ~halted;

	// a frozen pipeline rereads the operands of the instruction in execute.
	assign rf_ra_sel = stall ? e_ra_sel : d_ra_sel;
	assign rf_rb_sel = stall ? e_rb_sel : d_rb_sel;

	cpu_fetch fetch (.clk(clk), .i_rst(i_rst), .i_stall(stall),
		.i_branch_taken(branch_taken), .i_branch_pc(branch_pc), .i_halted(halted),
		.o_ibus_access(o_ibus_access), .o_ibus_addr(o_ibus_addr),
		.i_ibus_data(i_ibus_data), .i_ibus_ack(i_ibus_ack), .o_fd(fd));

	cpu_decode decode (.clk(clk), .i_rst(i_rst), .i_stall(stall), .i_flush(branch_taken),
		.i_fd(fd), .o_ra_sel(d_ra_sel), .o_rb_sel(d_rb_sel), .o_de(de));

	cpu_exec exec (.clk(clk), .i_rst(i_rst), .i_stall(stall), .i_de(de),
		.i_ra(fwd_ra), .i_rb(fwd_rb), .o_branch_taken(branch_taken),
		.o_branch_pc(branch_pc), .o_halted(halted), .o_em(em));

	cpu_memory memory (.clk(clk), .i_rst(i_rst), .i_stall(stall), .i_em(em),
		.o_stall(mem_stall), .o_dbus_access(o_dbus_access), .o_dbus_addr(o_dbus_addr),
		.o_dbus_wr_en(o_dbus_wr_en), .o_dbus_wr_val(o_dbus_wr_val),
		.i_dbus_data(i_dbus_data), .i_dbus_ack(i_dbus_ack), .o_mw(mw));

	cpu_regfile regfile (.clk(clk), .i_rst(i_rst), .i_ra_sel(rf_ra_sel),
		.i_rb_sel(rf_rb_sel), .i_mw(mw), .o_ra(rf_ra), .o_rb(rf_rb));

	// selects of the instruction now in execute.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			e_ra_sel <= '0;
			e_rb_sel <= '0;
		end else if (!stall) begin
			e_ra_sel <= d_ra_sel;
			e_rb_sel <= d_rb_sel;
		end
	end

	function automatic logic [`CPU_XLEN-1:0] fwd(input cpu_isa_pkg::reg_sel_t sel,
			input logic [`CPU_XLEN-1:0] rf_val);
		if (sel == '0)
			return rf_val;
		// youngest result wins.
		if (em.valid && em.update_rd && em.rd_sel == sel)
			return em.alu_out;
		if (mw.valid && mw.update_rd && mw.rd_sel == sel)
			return mw.wr_val;
		return rf_val;
	endfunction

	always_comb begin
		fwd_ra = fwd(e_ra_sel, rf_ra);
		fwd_rb = fwd(e_rb_sel, rf_rb);
	end

endmodule

/* rtl/cpu_decode.sv */
`include "cpu_defines.svh"

module cpu_decode (
	input  logic clk,
	input  logic i_rst,
	input  logic i_stall,
	input  logic i_flush,
	input  cpu_pipe_pkg::fd_t i_fd,
	output cpu_isa_pkg::reg_sel_t o_ra_sel,
	output cpu_isa_pkg::reg_sel_t o_rb_sel,
	output cpu_pipe_pkg::de_t o_de
);

	cpu_isa_pkg::instr_fields_t f;
	cpu_pipe_pkg::de_t dec;

	always_comb begin
		f.op = cpu_isa_pkg::opcode_e'(i_fd.instr[`CPU_OP_MSB:`CPU_OP_LSB]);
		f.rd = i_fd.instr[`CPU_RD_LSB +: 4];
		f.ra = i_fd.instr[`CPU_RA_LSB +: 4];
		f.rb = i_fd.instr[`CPU_RB_LSB +: 4];
		f.imm = i_fd.instr[`CPU_IMM_W-1:0];
	end

	always_comb begin
		dec = '0;
		dec.valid = i_fd.valid;
		dec.ra_sel = f.ra;
		// stores take their data register from the rd field.
		dec.rb_sel = (f.op == cpu_isa_pkg::STW) ? f.rd : f.rb;
		dec.rd_sel = f.rd;
		dec.pc_plus_4 = i_fd.pc_plus_4;
		dec.alu_op = cpu_isa_pkg::ALU_ADD;
		if (f.op == cpu_isa_pkg::MOVHI)
			dec.imm32 = {f.imm, 16'h0000};
		else
			dec.imm32 = {{16{f.imm[15]}}, f.imm};
		case (f.op)
			cpu_isa_pkg::ADD: dec.update_rd = 1'b1;
			cpu_isa_pkg::SUB: begin
				dec.alu_op = cpu_isa_pkg::ALU_SUB;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::AND: begin
				dec.alu_op = cpu_isa_pkg::ALU_AND;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::OR: begin
				dec.alu_op = cpu_isa_pkg::ALU_OR;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::XOR: begin
				dec.alu_op = cpu_isa_pkg::ALU_XOR;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::ADDI: begin
				dec.op2_imm = 1'b1;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::MOVHI: begin
				dec.alu_op = cpu_isa_pkg::ALU_PASS_B;
				dec.op2_imm = 1'b1;
				dec.update_rd = 1'b1;
			end
			cpu_isa_pkg::LDW: begin
				dec.op2_imm = 1'b1;
				dec.update_rd = 1'b1;
				dec.mem_load = 1'b1;
			end
			cpu_isa_pkg::STW: begin
				dec.op2_imm = 1'b1;
				dec.mem_store = 1'b1;
			end
			cpu_isa_pkg::BEQZ: dec.is_branch_zero = 1'b1;
			cpu_isa_pkg::JMP: dec.is_jump = 1'b1;
			cpu_isa_pkg::HALT: dec.is_halt = 1'b1;
			default: dec.update_rd = 1'b0;
		endcase
	end

	assign o_ra_sel = dec.ra_sel;
	assign o_rb_sel = dec.rb_sel;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_de <= '0;
		end else if (!i_stall) begin
			o_de <= dec;
			o_de.valid <= dec.valid & ~i_flush;
		end
	end

	a_known_op: assert property (@(posedge clk) disable iff (i_rst)
		i_fd.valid |-> i_fd.instr[`CPU_OP_MSB:`CPU_OP_LSB] <= 6'(cpu_isa_pkg::HALT));

endmodule

/* rtl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word and register file size.
`define CPU_XLEN 32
`define CPU_NREGS 16

// word address width shared by both buses.
`define CPU_ADDR_W 30

`define CPU_RESET_PC 32'h0000_0000

// instruction field positions.
`define CPU_OP_MSB 31
`define CPU_OP_LSB 26
`define CPU_RD_LSB 22
`define CPU_RA_LSB 18
`define CPU_RB_LSB 14
`define CPU_IMM_W 16

`endif

/* rtl/cpu_exec.sv */
`include "cpu_defines.svh"

module cpu_exec (
	input  logic clk,
	input  logic i_rst,
	input  logic i_stall,
	input  cpu_pipe_pkg::de_t i_de,
	input  logic [`CPU_XLEN-1:0] i_ra,
	input  logic [`CPU_XLEN-1:0] i_rb,
	output logic o_branch_taken,
	output logic [`CPU_XLEN-1:0] o_branch_pc,
	output logic o_halted,
	output cpu_pipe_pkg::em_t o_em
);

	logic live;
	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu_out;

	// nothing behind a halt is allowed to execute.
	assign live = i_de.valid & ~o_halted;
	assign op_b = i_de.op2_imm ? i_de.imm32 : i_rb;

	always_comb begin
		case (i_de.alu_op)
			cpu_isa_pkg::ALU_ADD: alu_out = i_ra + op_b;
			cpu_isa_pkg::ALU_SUB: alu_out = i_ra - op_b;
			cpu_isa_pkg::ALU_AND: alu_out = i_ra & op_b;
			cpu_isa_pkg::ALU_OR: alu_out = i_ra | op_b;
			cpu_isa_pkg::ALU_XOR: alu_out = i_ra ^ op_b;
			cpu_isa_pkg::ALU_PASS_B: alu_out = op_b;
			default: alu_out = '0;
		endcase
	end

	assign o_branch_pc = i_de.pc_plus_4 + {i_de.imm32[`CPU_XLEN-3:0], 2'b00};
	assign o_branch_taken = live &
		(i_de.is_jump | (i_de.is_branch_zero & (i_ra == '0)));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_halted <= 1'b0;
			o_em.valid <= 1'b0;
			o_em.update_rd <= 1'b0;
			o_em.mem_load <= 1'b0;
			o_em.mem_store <= 1'b0;
		end else if (!i_stall) begin
			o_halted <= o_halted | (live & i_de.is_halt);
			o_em.valid <= live;
			o_em.update_rd <= live & i_de.update_rd;
			o_em.mem_load <= live & i_de.mem_load;
			o_em.mem_store <= live & i_de.mem_store;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			o_em.alu_out <= alu_out;
			o_em.store_val <= i_rb;
			o_em.rd_sel <= i_de.rd_sel;
		end
	end

endmodule

/* rtl/cpu_fetch.sv */
`include "cpu_defines.svh"

module cpu_fetch (
	input  logic clk,
	input  logic i_rst,
	input  logic i_stall,
	input  logic i_branch_taken,
	input  logic [`CPU_XLEN-1:0] i_branch_pc,
	input  logic i_halted,
	output logic o_ibus_access,
	output logic [`CPU_ADDR_W-1:0] o_ibus_addr,
	input  logic [`CPU_XLEN-1:0] i_ibus_data,
	input  logic i_ibus_ack,
	output cpu_pipe_pkg::fd_t o_fd
);

	logic [`CPU_XLEN-1:0] fetch_pc;
	logic [`CPU_XLEN-1:0] held_word;
	logic [`CPU_XLEN-1:0] held_pc4;
	logic held;
	logic got;

	assign got = o_ibus_access & i_ibus_ack;
	assign o_ibus_addr = fetch_pc[`CPU_XLEN-1:2];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			fetch_pc <= `CPU_RESET_PC;
			o_ibus_access <= 1'b0;
			held <= 1'b0;
			o_fd <= '0;
		end else if (!i_stall) begin
			held <= 1'b0;
			// a word arriving with a redirect is dropped.
			o_fd.valid <= (held | got) & ~i_branch_taken;
			o_fd.instr <= held ? held_word : i_ibus_data;
			o_fd.pc_plus_4 <= held ? held_pc4 : fetch_pc + 32'd4;
			o_ibus_access <= ~i_halted;
			if (i_branch_taken)
				fetch_pc <= i_branch_pc;
			else if (got)
				fetch_pc <= fetch_pc + 32'd4;
		end else if (got) begin
			// pipeline frozen by the data bus; park the word.
			held <= 1'b1;
			fetch_pc <= fetch_pc + 32'd4;
			o_ibus_access <= 1'b0;
		end else if (!o_ibus_access && !held) begin
			o_ibus_access <= ~i_halted;
		end
	end

	always_ff @(posedge clk) begin
		if (i_stall && got) begin
			held_word <= i_ibus_data;
			held_pc4 <= fetch_pc + 32'd4;
		end
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (i_rst)
		o_ibus_access && !i_ibus_ack |=> o_ibus_access && $stable(o_ibus_addr));

endmodule

/* rtl/cpu_isa_pkg.sv */
`include "cpu_defines.svh"

package cpu_isa_pkg;

	typedef enum logic [5:0] {
		ADD   = 6'h00,
		SUB   = 6'h01,
		AND   = 6'h02,
		OR    = 6'h03,
		XOR   = 6'h04,
		ADDI  = 6'h05,
		MOVHI = 6'h06,
		LDW   = 6'h07,
		STW   = 6'h08,
		BEQZ  = 6'h09,
		JMP   = 6'h0a,
		HALT  = 6'h0b
	} opcode_e;

	typedef logic [3:0] reg_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_PASS_B = 3'd5
	} alu_op_e;

	// raw fields; rb and imm overlap in the encoding.
	typedef struct packed {
		opcode_e op;
		reg_sel_t rd;
		reg_sel_t ra;
		reg_sel_t rb;
		logic [`CPU_IMM_W-1:0] imm;
	} instr_fields_t;

endpackage

/* rtl/cpu_memory.sv */
`include "cpu_defines.svh"

module cpu_memory (
	input  logic clk,
	input  logic i_rst,
	input  logic i_stall,
	input  cpu_pipe_pkg::em_t i_em,
	output logic o_stall,
	output logic o_dbus_access,
	output logic [`CPU_ADDR_W-1:0] o_dbus_addr,
	output logic o_dbus_wr_en,
	output logic [`CPU_XLEN-1:0] o_dbus_wr_val,
	input  logic [`CPU_XLEN-1:0] i_dbus_data,
	input  logic i_dbus_ack,
	output cpu_pipe_pkg::mw_t o_mw
);

	logic done;
	logic [`CPU_XLEN-1:0] ld_buf;

	// done blocks a second access while fetch still holds the pipeline.
	assign o_dbus_access = i_em.valid & (i_em.mem_load | i_em.mem_store) & ~done;
	assign o_dbus_addr = i_em.alu_out[`CPU_XLEN-1:2];
	assign o_dbus_wr_en = i_em.mem_store;
	assign o_dbus_wr_val = i_em.store_val;
	assign o_stall = o_dbus_access & ~i_dbus_ack;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			done <= 1'b0;
			o_mw.valid <= 1'b0;
			o_mw.update_rd <= 1'b0;
		end else if (i_stall) begin
			if (o_dbus_access && i_dbus_ack)
				done <= 1'b1;
		end else begin
			done <= 1'b0;
			o_mw.valid <= i_em.valid;
			o_mw.update_rd <= i_em.valid & i_em.update_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (i_stall && o_dbus_access && i_dbus_ack)
			ld_buf <= i_dbus_data;
		if (!i_stall) begin
			o_mw.rd_sel <= i_em.rd_sel;
			if (i_em.mem_load)
				o_mw.wr_val <= done ? ld_buf : i_dbus_data;
			else
				o_mw.wr_val <= i_em.alu_out;
		end
	end

	a_one_access: assert property (@(posedge clk) disable iff (i_rst)
		o_dbus_access && !i_dbus_ack |=> o_dbus_access && $stable(o_dbus_addr)
			&& $stable(o_dbus_wr_en));

endmodule

/* rtl/cpu_pipe_pkg.sv */
`include "cpu_defines.svh"

package cpu_pipe_pkg;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] instr;
		logic [`CPU_XLEN-1:0] pc_plus_4;
	} fd_t;

	typedef struct packed {
		logic valid;
		cpu_isa_pkg::reg_sel_t ra_sel;
		cpu_isa_pkg::reg_sel_t rb_sel;
		cpu_isa_pkg::reg_sel_t rd_sel;
		logic update_rd;
		cpu_isa_pkg::alu_op_e alu_op;
		logic op2_imm;
		logic [`CPU_XLEN-1:0] imm32;
		logic [`CPU_XLEN-1:0] pc_plus_4;
		logic mem_load;
		logic mem_store;
		logic is_branch_zero;
		logic is_jump;
		logic is_halt;
	} de_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] alu_out;
		logic [`CPU_XLEN-1:0] store_val;
		cpu_isa_pkg::reg_sel_t rd_sel;
		logic update_rd;
		logic mem_load;
		logic mem_store;
	} em_t;

	// also the register file write port.
	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] wr_val;
		cpu_isa_pkg::reg_sel_t rd_sel;
		logic update_rd;
	} mw_t;

endpackage

/* rtl/cpu_regfile.sv */
`include "cpu_defines.svh"

module cpu_regfile (
	input  logic clk,
	input  logic i_rst,
	input  cpu_isa_pkg::reg_sel_t i_ra_sel,
	input  cpu_isa_pkg::reg_sel_t i_rb_sel,
	input  cpu_pipe_pkg::mw_t i_mw,
	output logic [`CPU_XLEN-1:0] o_ra,
	output logic [`CPU_XLEN-1:0] o_rb
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
	logic wr;

	assign wr = i_mw.valid & i_mw.update_rd & (i_mw.rd_sel != '0);

	function automatic logic [`CPU_XLEN-1:0] rd_port(input cpu_isa_pkg::reg_sel_t sel);
		if (sel == '0)
			return '0;
		// same-cycle write passes through.
		if (wr && i_mw.rd_sel == sel)
			return i_mw.wr_val;
		return regs[sel];
	endfunction

	always_ff @(posedge clk) begin
		if (wr)
			regs[i_mw.rd_sel] <= i_mw.wr_val;
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_ra <= '0;
			o_rb <= '0;
		end else begin
			o_ra <= rd_port(i_ra_sel);
			o_rb <= rd_port(i_rb_sel);
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_cpu_core -o tb_cpu_core
status=0
./obj_dir/tb_cpu_core > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* test/program_input.txt */
// hex words: @00 program, @40 initial data words,
// @80 expected store count, then (dbus word address, store value) pairs in order
@00
14400123 1480FFF0 00C48000 20C00080
05048000 1940ABCD 21000084 0D944000
11D88000 0A1D8000 21400088 2180008C
21C00090 22000094 1E400004 1E800000
14640008 22A40058 2040009C 1C800008
14C00005 240C0001 20C000A0 24080001
204000A4 150C0010 28000002 210000A8
15007777 210000AC 2C000000 20C000B0
@40
CAFE0001 00000040 00000000
@80
0000000A
00000020 00000113
00000021 00000133
00000022 ABCD0000
00000023 ABCD0123
00000024 5432FED3
00000025 00000003
00000026 CAFE0001
00000027 00000048
00000028 00000005
0000002B 00000015

/* test/tb_cpu_core.sv */
`include "cpu_defines.svh"

module tb_cpu_core;

	localparam int IMG_WORDS = 256;
	localparam int MEM_WORDS = 64;
	localparam int EXP_BASE = 128;
	localparam logic [5:0] HALT_OP = 6'h0b;

	logic clk;
	logic i_rst;
	logic running;
	logic ibus_access;
	logic [`CPU_ADDR_W-1:0] ibus_addr;
	logic [`CPU_XLEN-1:0] ibus_data;
	logic ibus_ack;
	logic dbus_access;
	logic [`CPU_ADDR_W-1:0] dbus_addr;
	logic dbus_wr_en;
	logic [`CPU_XLEN-1:0] dbus_wr_val;
	logic [`CPU_XLEN-1:0] dbus_data;
	logic dbus_ack;

	// program, data and expected stores share one image.
	logic [`CPU_XLEN-1:0] image [IMG_WORDS];
	logic [`CPU_XLEN-1:0] dmem [MEM_WORDS];
	int errors;
	int stores;
	int exp_stores;
	int prog_len;
	int ibus_wait;
	int dbus_wait;
	logic ibus_busy;
	logic dbus_busy;
	logic [`CPU_ADDR_W-1:0] ibus_req_addr;
	logic [`CPU_ADDR_W-1:0] dbus_req_addr;

	cpu_core uut (.clk(clk), .i_rst(i_rst), .o_running(running),
		.o_ibus_access(ibus_access), .o_ibus_addr(ibus_addr),
		.i_ibus_data(ibus_data), .i_ibus_ack(ibus_ack),
		.o_dbus_access(dbus_access), .o_dbus_addr(dbus_addr),
		.o_dbus_wr_en(dbus_wr_en), .o_dbus_wr_val(dbus_wr_val),
		.i_dbus_data(dbus_data), .i_dbus_ack(dbus_ack));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t %s expected %08h actual %08h", $time, name, expected, actual);
		end
	endtask

	task automatic print_counts();
		$display("errors %0d, stores %0d of %0d", errors, stores, exp_stores);
	endtask

	task automatic check_store();
		if (stores >= exp_stores) begin
			errors++;
			$display("%0t extra store to word address %08h", $time, 32'(dbus_addr));
		end else begin
			compare_value("o_dbus_addr", image[8'(EXP_BASE + 1 + 2 * stores)], 32'(dbus_addr));
			compare_value("o_dbus_wr_val", image[8'(EXP_BASE + 2 + 2 * stores)], dbus_wr_val);
		end
		stores++;
	endtask

	// instruction memory with 0 to 3 cycles of ack delay.
	task automatic step_ibus();
		ibus_ack = 1'b0;
		if (!ibus_access)
			return;
		if (!ibus_busy) begin
			ibus_busy = 1'b1;
			ibus_req_addr = ibus_addr;
			ibus_wait = $urandom_range(3, 0);
		end
		compare_value("o_ibus_addr", 32'(ibus_req_addr), 32'(ibus_addr));
		if (ibus_wait > 0) begin
			ibus_wait--;
			return;
		end
		ibus_busy = 1'b0;
		ibus_ack = 1'b1;
		if (ibus_addr[`CPU_ADDR_W-1:6] != '0) begin
			errors++;
			$display("%0t instruction fetch outside program memory", $time);
		end
		ibus_data = image[{2'b00, ibus_addr[5:0]}];
	endtask

	task automatic step_dbus();
		dbus_ack = 1'b0;
		if (!dbus_access)
			return;
		if (!dbus_busy) begin
			dbus_busy = 1'b1;
			dbus_req_addr = dbus_addr;
			dbus_wait = $urandom_range(3, 0);
		end
		compare_value("o_dbus_addr", 32'(dbus_req_addr), 32'(dbus_addr));
		if (dbus_wait > 0) begin
			dbus_wait--;
			return;
		end
		dbus_busy = 1'b0;
		dbus_ack = 1'b1;
		if (dbus_addr[`CPU_ADDR_W-1:6] != '0) begin
			errors++;
			$display("%0t data access outside data memory", $time);
		end else if (dbus_wr_en) begin
			dmem[dbus_addr[5:0]] = dbus_wr_val;
			check_store();
		end else begin
			dbus_data = dmem[dbus_addr[5:0]];
		end
	endtask

	initial begin : bus_models
		forever begin
			@(posedge clk);
			#2;
			step_ibus();
			step_dbus();
		end
	end

	initial begin : watchdog
		wait (prog_len > 0);
		repeat (prog_len * 64 + 3) @(posedge clk);
		errors++;
		$display("timeout, the core did not halt within %0d cycles", prog_len * 64);
		print_counts();
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		stores = 0;
		ibus_busy = 1'b0;
		dbus_busy = 1'b0;
		ibus_wait = 0;
		dbus_wait = 0;
		i_rst = 1'b1;
		ibus_ack = 1'b0;
		ibus_data = '0;
		dbus_ack = 1'b0;
		dbus_data = '0;
		void'($urandom(22));
		for (int i = 0; i < IMG_WORDS; i++)
			image[8'(i)] = {HALT_OP, 26'(i)};
		$readmemh("test/program_input.txt", image);
		for (int i = 0; i < MEM_WORDS; i++)
			dmem[6'(i)] = image[8'(MEM_WORDS + i)];
		exp_stores = image[8'(EXP_BASE)];
		prog_len = 0;
		while (prog_len < MEM_WORDS - 1 && image[8'(prog_len)][31:26] != HALT_OP)
			prog_len++;
		prog_len++;
		repeat (3) @(posedge clk);
		#2;
		i_rst = 1'b0;
		// run until halt.
		do begin
			@(posedge clk);
			#5;
		end while (running);
		compare_value("store count at halt", 32'(exp_stores), 32'(stores));
		// a fetch already on the bus may finish.
		while (ibus_access) begin
			@(posedge clk);
			#5;
		end
		repeat (16) begin
			@(posedge clk);
			#5;
			compare_value("o_ibus_access", 32'd0, 32'(ibus_access));
		end
		compare_value("store count", 32'(exp_stores), 32'(stores));
		print_counts();
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
